/* hw/amiga_crop.sv */
// single clock domain; all inputs must already be synchronous to clk_sys
`default_nettype none
`timescale 1ns/10ps

module amiga_crop #(
	parameter int CNT_W = 12
) (
	input  wire logic                          clk_sys,
	input  wire logic                          reset,
	input  wire logic                          hs,
	input  wire logic                          vs,
	input  wire logic                          hblank,
	input  wire logic                          vblank_in,
	input  wire crop_pkg::res_t                res,
	input  wire logic                          key_level,
	input  wire logic          [1:0]           key_type,
	input  wire logic          [7:0]           key_code,
	output logic                               video_de,
	output logic               [CNT_W-1:0]     scr_hsize,
	output logic               [CNT_W-1:0]     scr_vsize,
	output logic               [CNT_W-1:0]     scr_hbl_l,
	output logic               [CNT_W-1:0]     scr_hbl_r,
	output logic               [CNT_W-1:0]     scr_vbl_t,
	output logic               [CNT_W-1:0]     scr_vbl_b,
	output crop_pkg::res_t                     scr_res,
	output logic               [crop_pkg::FLG_W-1:0] scr_flg
);

	logic [CNT_W-1:0] hbl_l, hbl_r, vbl_t, vbl_b; // live crop offsets
	logic [CNT_W-1:0] hsize, vsize;
	logic             line_blank;
	logic             frame_start;

	crop_keys #(.CNT_W(CNT_W)) u_keys (
		.clk_sys, .reset, .key_level, .key_type, .key_code,
		.hbl_l, .hbl_r, .vbl_t, .vbl_b
	);

	line_timer #(.CNT_W(CNT_W)) u_line (
		.clk_sys, .reset, .hs, .hblank, .hbl_l, .hbl_r,
		.line_blank, .hsize
	);

	frame_timer #(.CNT_W(CNT_W)) u_frame (
		.clk_sys, .reset, .hs, .vs, .vblank_in, .line_blank,
		.vbl_t, .vbl_b, .vsize, .video_de, .frame_start
	);

	screen_snapshot #(.CNT_W(CNT_W)) u_snap (
		.clk_sys, .reset, .frame_start, .hsize, .vsize,
		.hbl_l, .hbl_r, .vbl_t, .vbl_b, .res,
		.scr_hsize, .scr_vsize, .scr_hbl_l, .scr_hbl_r,
		.scr_vbl_t, .scr_vbl_b, .scr_res, .scr_flg
	);

endmodule

`default_nettype wire

/* hw/crop_keys.sv */
// key_level must toggle once per event with key_type and key_code stable around the toggle
`default_nettype none
`timescale 1ns/10ps

module crop_keys #(
	parameter int CNT_W = 12
) (
	input  wire logic             clk_sys,
	input  wire logic             reset,
	input  wire logic             key_level,
	input  wire logic [1:0]       key_type,
	input  wire logic [7:0]       key_code,
	output logic      [CNT_W-1:0] hbl_l,
	output logic      [CNT_W-1:0] hbl_r,
	output logic      [CNT_W-1:0] vbl_t,
	output logic      [CNT_W-1:0] vbl_b
);

	localparam logic [CNT_W-1:0] HSTEP_C = CNT_W'(crop_pkg::H_STEP);
	localparam logic [CNT_W-1:0] VSTEP_C = CNT_W'(crop_pkg::V_STEP);

	logic old_level;
	logic alt;        // either alt held
	logic key_event;

	assign key_event = (old_level ^ key_level) && (key_type == crop_pkg::KEY_TYPE_KBD);

	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			old_level <= 1'b0;
			alt       <= 1'b0;
			hbl_l     <= '0;
			hbl_r     <= '0;
			vbl_t     <= '0;
			vbl_b     <= '0;
		end else begin
			old_level <= key_level;

			if (key_event) begin
				case (crop_pkg::key_code_e'(key_code))
					crop_pkg::KEY_BACKSPACE: begin
						hbl_l <= '0;
						hbl_r <= '0;
						vbl_t <= '0;
						vbl_b <= '0;
					end
					crop_pkg::KEY_UP: begin
						if (alt) vbl_b <= vbl_b + VSTEP_C;
						else     vbl_t <= vbl_t + VSTEP_C;
					end
					crop_pkg::KEY_DOWN: begin
						if (alt) vbl_b <= vbl_b - VSTEP_C;
						else     vbl_t <= vbl_t - VSTEP_C;
					end
					crop_pkg::KEY_LEFT: begin
						if (alt) hbl_r <= hbl_r + HSTEP_C;
						else     hbl_l <= hbl_l + HSTEP_C;
					end
					crop_pkg::KEY_RIGHT: begin
						if (alt) hbl_r <= hbl_r - HSTEP_C;
						else     hbl_l <= hbl_l - HSTEP_C;
					end
					crop_pkg::KEY_ALT_L, crop_pkg::KEY_ALT_R:
						alt <= 1'b1;
					crop_pkg::KEY_ALT_L_UP, crop_pkg::KEY_ALT_R_UP:
						alt <= 1'b0;
					default: ; // other keys pass through untouched
				endcase
			end
		end
	end

endmodule

`default_nettype wire

/* hw/crop_pkg.sv */
// shared key codes and crop constants; the step and margin values assume a CNT_W of at least 8
`default_nettype none

package crop_pkg;

	// accepted keyboard codes with release codes carrying bit 7
	typedef enum logic [7:0] {
		KEY_BACKSPACE = 8'h41, // clears all crop offsets
		KEY_UP        = 8'h4C,
		KEY_DOWN      = 8'h4D,
		KEY_RIGHT     = 8'h4E,
		KEY_LEFT      = 8'h4F,
		KEY_ALT_L     = 8'h64,
		KEY_ALT_R     = 8'h65,
		KEY_ALT_L_UP  = 8'hE4,
		KEY_ALT_R_UP  = 8'hE5
	} key_code_e;

	localparam logic [1:0] KEY_TYPE_KBD = 2'd3; // type value for keyboard data

	typedef logic [1:0] res_t; // resolution code from the core

	localparam int FLG_W = 7; // change counter width

	// crop offset steps per key press
	localparam int H_STEP = 4;
	localparam int V_STEP = 1;

	// crop edges act this far ahead of the captured blank count
	localparam int H_LEAD = 2;
	localparam int V_LEAD = 1;

	// forced blanking window
	localparam int FORCE_H_START  = 8;
	localparam int FORCE_H_MARGIN = 8; // before measured line length
	localparam int FORCE_V_START  = 1;
	localparam int FORCE_V_MARGIN = 3; // before measured line count

endpackage

`default_nettype wire

/* hw/frame_timer.sv */
// vs is active low and vblank_in active high; vertical crop acts only at line_blank falls
`default_nettype none
`timescale 1ns/10ps

module frame_timer #(
	parameter int CNT_W = 12
) (
	input  wire logic             clk_sys,
	input  wire logic             reset,
	input  wire logic             hs,
	input  wire logic             vs,
	input  wire logic             vblank_in,
	input  wire logic             line_blank,
	input  wire logic [CNT_W-1:0] vbl_t,
	input  wire logic [CNT_W-1:0] vbl_b,
	output logic      [CNT_W-1:0] vsize,
	output logic                  video_de,
	output logic                  frame_start
);

	localparam logic [CNT_W-1:0] LEAD_C    = CNT_W'(crop_pkg::V_LEAD);
	localparam logic [CNT_W-1:0] FSTART_C  = CNT_W'(crop_pkg::FORCE_V_START);
	localparam logic [CNT_W-1:0] FMARGIN_C = CNT_W'(crop_pkg::FORCE_V_MARGIN);

	logic             vblank;     // core vblank or sync
	logic             old_hs;
	logic             old_vs;
	logic             old_vblank;
	logic             old_hbl;
	logic [CNT_W-1:0] vcnt;       // lines since vs rise
	logic [CNT_W-1:0] vsta;       // line at vblank rise
	logic [CNT_W-1:0] vend;       // line at vblank fall
	logic [CNT_W-1:0] vmax;       // frame length at vs fall
	logic             svbl;       // crop vblank
	logic             fvbl;       // forced vblank

	assign vblank = vblank_in | ~vs;

	// line counter and vertical captures
	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			old_hs     <= 1'b1;
			old_vs     <= 1'b1;
			old_vblank <= 1'b1;
			vcnt       <= '0;
			vsta       <= '0;
			vend       <= '0;
			vmax       <= '0;
			vsize      <= '0;
		end else begin
			old_hs     <= hs;
			old_vs     <= vs;
			old_vblank <= vblank;

			if (!vs)
				vcnt <= '0;
			else if (old_hs & ~hs)
				vcnt <= vcnt + 1'b1; // one step per hs fall

			if (old_vblank & ~vblank)
				vend <= vcnt;
			if (~old_vblank & vblank) begin
				vsta  <= vcnt;
				vsize <= vcnt - vend;
			end
			if (old_vs & ~vs)
				vmax <= vcnt;
		end
	end

	// vertical crop, updated at the start of each visible line segment
	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			old_hbl  <= 1'b1;
			svbl     <= 1'b1;
			fvbl     <= 1'b1;
			video_de <= 1'b0;
		end else begin
			old_hbl <= line_blank;

			if (old_hbl & ~line_blank) begin
				if (vcnt == vend + vbl_t - LEAD_C)
					svbl <= 1'b0; // top edge opens
				if (vcnt == vsta + vbl_b - LEAD_C)
					svbl <= 1'b1; // bottom edge closes

				if (vcnt == FSTART_C)
					fvbl <= 1'b0;
				if (vcnt == vmax - FMARGIN_C)
					fvbl <= 1'b1;
			end

			video_de <= ~line_blank & ~(fvbl | svbl);
		end
	end

	assign frame_start = old_vblank & ~vblank; // first active cycle of a frame

endmodule

`default_nettype wire

/* hw/line_timer.sv */
// hs is active low and hblank active high; hsize is valid only after one complete line
`default_nettype none
`timescale 1ns/10ps

module line_timer #(
	parameter int CNT_W = 12
) (
	input  wire logic             clk_sys,
	input  wire logic             reset,
	input  wire logic             hs,
	input  wire logic             hblank,
	input  wire logic [CNT_W-1:0] hbl_l,
	input  wire logic [CNT_W-1:0] hbl_r,
	output logic                  line_blank,
	output logic      [CNT_W-1:0] hsize
);

	localparam logic [CNT_W-1:0] LEAD_C   = CNT_W'(crop_pkg::H_LEAD);
	localparam logic [CNT_W-1:0] FSTART_C = CNT_W'(crop_pkg::FORCE_H_START);
	localparam logic [CNT_W-1:0] FMARGIN_C = CNT_W'(crop_pkg::FORCE_H_MARGIN);

	logic             old_hs;
	logic             old_hblank;
	logic [CNT_W-1:0] hcnt;   // cycles since hs rise
	logic [CNT_W-1:0] hsta;   // count at hblank rise
	logic [CNT_W-1:0] hend;   // count at hblank fall
	logic [CNT_W-1:0] hmax;   // line length at hs fall
	logic             shbl;   // crop blank
	logic             fhbl;   // forced blank

	logic             hblank_fall;
	logic             hblank_rise;

	assign hblank_fall = old_hblank & ~hblank;
	assign hblank_rise = ~old_hblank & hblank;

	// edge history and captures
	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			old_hs     <= 1'b1;
			old_hblank <= 1'b1;
			hcnt       <= '0;
			hsta       <= '0;
			hend       <= '0;
			hmax       <= '0;
			hsize      <= '0;
		end else begin
			old_hs     <= hs;
			old_hblank <= hblank;

			if (!hs)
				hcnt <= '0; // held through sync
			else
				hcnt <= hcnt + 1'b1;

			if (hblank_fall)
				hend <= hcnt;
			if (hblank_rise) begin
				hsta  <= hcnt;
				hsize <= hcnt - hend; // same lag on both edges
			end
			if (old_hs & ~hs)
				hmax <= hcnt;
		end
	end

	// crop and forced horizontal blank
	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			shbl <= 1'b1;
			fhbl <= 1'b1;
		end else begin
			if (hcnt == hend + hbl_l - LEAD_C)
				shbl <= 1'b0; // left edge opens
			if (hcnt == hsta + hbl_r - LEAD_C)
				shbl <= 1'b1; // right edge closes

			if (hcnt == FSTART_C)
				fhbl <= 1'b0;
			if (hcnt == hmax - FMARGIN_C)
				fhbl <= 1'b1;
		end
	end

	assign line_blank = fhbl | shbl | ~hs;

endmodule

`default_nettype wire

/* hw/screen_snapshot.sv */
// values reflect the frame_start of the previous active frame; scr_flg wraps at its width
`default_nettype none
`timescale 1ns/10ps

module screen_snapshot #(
	parameter int CNT_W = 12
) (
	input  wire logic                          clk_sys,
	input  wire logic                          reset,
	input  wire logic                          frame_start,
	input  wire logic          [CNT_W-1:0]     hsize,
	input  wire logic          [CNT_W-1:0]     vsize,
	input  wire logic          [CNT_W-1:0]     hbl_l,
	input  wire logic          [CNT_W-1:0]     hbl_r,
	input  wire logic          [CNT_W-1:0]     vbl_t,
	input  wire logic          [CNT_W-1:0]     vbl_b,
	input  wire crop_pkg::res_t                res,
	output logic               [CNT_W-1:0]     scr_hsize,
	output logic               [CNT_W-1:0]     scr_vsize,
	output logic               [CNT_W-1:0]     scr_hbl_l,
	output logic               [CNT_W-1:0]     scr_hbl_r,
	output logic               [CNT_W-1:0]     scr_vbl_t,
	output logic               [CNT_W-1:0]     scr_vbl_b,
	output crop_pkg::res_t                     scr_res,
	output logic               [crop_pkg::FLG_W-1:0] scr_flg
);

	logic geom_change;

	// compare against the previous snapshot
	assign geom_change = (scr_res != res) || (scr_vsize != vsize) || (scr_hsize != hsize);

	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			scr_hsize <= '0;
			scr_vsize <= '0;
			scr_hbl_l <= '0;
			scr_hbl_r <= '0;
			scr_vbl_t <= '0;
			scr_vbl_b <= '0;
			scr_res   <= '0;
			scr_flg   <= '0;
		end else if (frame_start) begin
			scr_hsize <= hsize;
			scr_vsize <= vsize;
			scr_hbl_l <= hbl_l;
			scr_hbl_r <= hbl_r;
			scr_vbl_t <= vbl_t;
			scr_vbl_b <= vbl_b;
			scr_res   <= res;
			if (geom_change)
				scr_flg <= scr_flg + 1'b1; // host rereads geometry
		end
	end

endmodule

`default_nettype wire

/* run_sim.sh */
#!/bin/sh
# Builds the amiga_crop testbench with Verilator and runs it.
# The result is decided by the pass line in the simulation output.
set -e

cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal \
	-f sim.f \
	--top-module tb_amiga_crop \
	-o tb_amiga_crop_sim

out=$(./obj_dir/tb_amiga_crop_sim)
printf '%s\n' "$out"

if printf '%s\n' "$out" | grep -qF '*** PASSED ***'; then
	echo "simulation run ok"
else
	echo "simulation run reported errors"
	exit 1
fi

/* sim.f */
hw/crop_pkg.sv
hw/line_timer.sv
hw/frame_timer.sv
hw/crop_keys.sv
hw/screen_snapshot.sv
hw/amiga_crop.sv
testbench/tb_amiga_crop.sv

/* testbench/tb_amiga_crop.sv */
// fixed 200x60 raster with vsync of 3 lines; expected de count holds only for offsets inside the forced window
`default_nettype none
`timescale 1ns/10ps

module tb_amiga_crop;

	localparam int CNT_W     = 12;
	localparam int FW        = crop_pkg::FLG_W;
	localparam int H_TOTAL   = 200;
	localparam int V_TOTAL   = 60;
	localparam int VS_W      = 3;  // vsync lines
	localparam int FRAME_CYC = H_TOTAL * V_TOTAL;
	localparam logic [1:0] KBD = crop_pkg::KEY_TYPE_KBD;
	localparam logic [CNT_W-1:0] HSTEP = CNT_W'(crop_pkg::H_STEP);
	localparam logic [CNT_W-1:0] VSTEP = CNT_W'(crop_pkg::V_STEP);

	logic                 clk_sys = 1'b0;
	logic                 reset;
	logic                 hs = 1'b1;
	logic                 vs = 1'b1;
	logic                 hblank = 1'b1;
	logic                 vblank_in = 1'b1;
	crop_pkg::res_t       res = '0;
	logic                 key_level;
	logic [1:0]           key_type;
	logic [7:0]           key_code;
	logic                 video_de;
	logic [CNT_W-1:0]     scr_hsize, scr_vsize, scr_hbl_l, scr_hbl_r, scr_vbl_t, scr_vbl_b;
	crop_pkg::res_t       scr_res;
	logic [FW-1:0]        scr_flg;

	// raster for the next frame, copied at line 0
	int nxt_hs_w = 16;
	int nxt_a0 = 40;
	int nxt_a1 = 170;
	int nxt_v0 = 10;
	int nxt_v1 = 50;
	crop_pkg::res_t nxt_res = '0;
	int cur_hs_w;
	int cur_a0;
	int cur_a1;
	int cur_v0;
	int cur_v1;
	crop_pkg::res_t cur_res;
	int hpos = H_TOTAL - 1;
	int vline = V_TOTAL - 1;

	logic [CNT_W-1:0] m_hbl_l, m_hbl_r, m_vbl_t, m_vbl_b; // offset model
	logic             m_alt;
	int               mismatch_errs = 0;
	int               timeout_errs = 0;

	always #5 clk_sys = ~clk_sys;

	amiga_crop #(.CNT_W(CNT_W)) u_dut (
		.clk_sys, .reset, .hs, .vs, .hblank, .vblank_in, .res,
		.key_level, .key_type, .key_code, .video_de,
		.scr_hsize, .scr_vsize, .scr_hbl_l, .scr_hbl_r,
		.scr_vbl_t, .scr_vbl_b, .scr_res, .scr_flg
	);

	// video generator
	always @(posedge clk_sys) begin
		if (hpos == H_TOTAL - 1) begin
			hpos = 0;
			if (vline == V_TOTAL - 1) begin
				vline = 0;
				cur_hs_w = nxt_hs_w;
				cur_a0 = nxt_a0;
				cur_a1 = nxt_a1;
				cur_v0 = nxt_v0;
				cur_v1 = nxt_v1;
				cur_res = nxt_res;
			end else begin
				vline = vline + 1;
			end
		end else begin
			hpos = hpos + 1;
		end
		hs        <= (hpos >= cur_hs_w);
		hblank    <= !(hpos >= cur_a0 && hpos < cur_a1);
		vs        <= (vline >= VS_W);
		vblank_in <= !(vline >= cur_v0 && vline < cur_v1);
		res       <= cur_res;
	end

	function automatic void ref_geometry(
		input int a0, input int a1, input int v0, input int v1,
		input logic [CNT_W-1:0] l, input logic [CNT_W-1:0] r,
		input logic [CNT_W-1:0] t, input logic [CNT_W-1:0] b,
		output logic [CNT_W-1:0] e_hsize, output logic [CNT_W-1:0] e_vsize, output int e_de);
		int w;
		int h;
		e_hsize = CNT_W'(a1 - a0);    // hblank-low cycles
		e_vsize = CNT_W'(v1 - v0);    // active lines
		w = a1 - a0 - int'(l) + int'(r);
		h = v1 - v0 - int'(t) + int'(b);
		e_de = w * h;
	endfunction

	task automatic check_size(input string name, input logic [CNT_W-1:0] exp,
		input logic [CNT_W-1:0] act);
		if (act !== exp) begin
			mismatch_errs++;
			$display("Mismatch at %0t: %s expected %0d, actual %0d", $time, name, exp, act);
		end
	endtask

	task automatic check_res(input string name, input crop_pkg::res_t exp,
		input crop_pkg::res_t act);
		if (act !== exp) begin
			mismatch_errs++;
			$display("Mismatch at %0t: %s expected %0d, actual %0d", $time, name, exp, act);
		end
	endtask

	task automatic check_flg(input string name, input logic [FW-1:0] exp,
		input logic [FW-1:0] act);
		if (act !== exp) begin
			mismatch_errs++;
			$display("Mismatch at %0t: %s expected %0d, actual %0d", $time, name, exp, act);
		end
	endtask

	task automatic check_count(input string name, input int exp, input int act);
		if (act != exp) begin
			mismatch_errs++;
			$display("Mismatch at %0t: %s expected %0d, actual %0d", $time, name, exp, act);
		end
	endtask

	task automatic wait_vs_falls(input int n);
		int   seen;
		int   cycles;
		logic prev_vs;
		seen = 0;
		cycles = 0;
		prev_vs = vs;
		while (seen < n && cycles < n * 2 * FRAME_CYC) begin
			@(negedge clk_sys);
			cycles++;
			if (prev_vs && !vs)
				seen++;
			prev_vs = vs;
		end
		if (seen < n) begin
			timeout_errs++;
			$display("Timeout at %0t: vsync fell %0d of %0d times", $time, seen, n);
		end
	endtask

	// de cycles from here up to the next vsync fall
	task automatic count_de_frame(output int cnt);
		int   cycles;
		logic prev_vs;
		logic done;
		cnt = 0;
		cycles = 0;
		done = 1'b0;
		prev_vs = vs;
		while (!done && cycles < 2 * FRAME_CYC) begin
			@(negedge clk_sys);
			cycles++;
			if (prev_vs && !vs)
				done = 1'b1;
			else if (video_de)
				cnt++;
			prev_vs = vs;
		end
		if (!done) begin
			timeout_errs++;
			$display("Timeout at %0t: no vsync fall while counting video_de", $time);
		end
	endtask

	task automatic apply_key_model(input logic [7:0] kcode);
		case (kcode)
			crop_pkg::KEY_BACKSPACE: begin
				m_hbl_l = '0;
				m_hbl_r = '0;
				m_vbl_t = '0;
				m_vbl_b = '0;
			end
			crop_pkg::KEY_UP: begin
				if (m_alt)
					m_vbl_b = m_vbl_b + VSTEP;
				else
					m_vbl_t = m_vbl_t + VSTEP;
			end
			crop_pkg::KEY_DOWN: begin
				if (m_alt)
					m_vbl_b = m_vbl_b - VSTEP;
				else
					m_vbl_t = m_vbl_t - VSTEP;
			end
			crop_pkg::KEY_LEFT: begin
				if (m_alt)
					m_hbl_r = m_hbl_r + HSTEP;
				else
					m_hbl_l = m_hbl_l + HSTEP;
			end
			crop_pkg::KEY_RIGHT: begin
				if (m_alt)
					m_hbl_r = m_hbl_r - HSTEP;
				else
					m_hbl_l = m_hbl_l - HSTEP;
			end
			crop_pkg::KEY_ALT_L, crop_pkg::KEY_ALT_R:
				m_alt = 1'b1;
			crop_pkg::KEY_ALT_L_UP, crop_pkg::KEY_ALT_R_UP:
				m_alt = 1'b0;
			default: ;
		endcase
	endtask

	task automatic send_key(input logic [1:0] ktype, input logic [7:0] kcode);
		@(posedge clk_sys);
		key_type <= ktype;
		key_code <= kcode;
		@(posedge clk_sys);
		key_level <= ~key_level;
		repeat (6) @(posedge clk_sys); // idle after the event
		if (ktype == KBD)
			apply_key_model(kcode);
	endtask

	// settle, then compare snapshot and one frame of de
	task automatic check_frame(input int settle);
		logic [CNT_W-1:0] e_hsize;
		logic [CNT_W-1:0] e_vsize;
		int               e_de;
		int               de_cnt;
		wait_vs_falls(settle);
		ref_geometry(nxt_a0, nxt_a1, nxt_v0, nxt_v1, m_hbl_l, m_hbl_r, m_vbl_t, m_vbl_b,
			e_hsize, e_vsize, e_de);
		check_size("scr_hsize", e_hsize, scr_hsize);
		check_size("scr_vsize", e_vsize, scr_vsize);
		check_size("scr_hbl_l", m_hbl_l, scr_hbl_l);
		check_size("scr_hbl_r", m_hbl_r, scr_hbl_r);
		check_size("scr_vbl_t", m_vbl_t, scr_vbl_t);
		check_size("scr_vbl_b", m_vbl_b, scr_vbl_b);
		check_res("scr_res", nxt_res, scr_res);
		count_de_frame(de_cnt);
		check_count("video_de cycles", e_de, de_cnt);
	endtask

	initial begin
		int            g;
		logic [FW-1:0] flg_exp;
		void'($urandom(32'h02cf2bc0));
		reset = 1'b1;
		key_level = 1'b0;
		key_type = 2'd0;
		key_code = 8'h00;
		m_hbl_l = '0;
		m_hbl_r = '0;
		m_vbl_t = '0;
		m_vbl_b = '0;
		m_alt = 1'b0;
		repeat (16) @(posedge clk_sys);
		reset <= 1'b0;

		for (g = 0; g < 2; g++) begin
			nxt_hs_w = 8 + int'($urandom % 17);
			nxt_a0 = nxt_hs_w + 12 + int'($urandom % 29);
			nxt_a1 = nxt_a0 + 40 + int'($urandom % 32'(146 - nxt_a0)); // ends by 185
			nxt_v0 = 6 + int'($urandom % 10);
			nxt_v1 = nxt_v0 + 20 + int'($urandom % 32'(35 - nxt_v0));
			check_frame(3);
		end
		nxt_hs_w = 16;
		nxt_a0 = 40;
		nxt_a1 = 170;
		nxt_v0 = 10;
		nxt_v1 = 50;
		check_frame(3);

		// one step per changed snapshot
		flg_exp = scr_flg;
		nxt_res = 2'd1;
		check_frame(3);
		flg_exp = flg_exp + FW'(1);
		check_flg("scr_flg", flg_exp, scr_flg);
		check_frame(2);
		check_flg("scr_flg", flg_exp, scr_flg);
		nxt_a1 = 160;
		check_frame(3);
		flg_exp = flg_exp + FW'(1);
		check_flg("scr_flg", flg_exp, scr_flg);
		nxt_v1 = 44;
		check_frame(3);
		flg_exp = flg_exp + FW'(1);
		check_flg("scr_flg", flg_exp, scr_flg);
		check_frame(2);
		check_flg("scr_flg", flg_exp, scr_flg);

		send_key(KBD, crop_pkg::KEY_UP);
		send_key(KBD, crop_pkg::KEY_UP);
		send_key(KBD, crop_pkg::KEY_LEFT);
		check_frame(3);
		send_key(KBD, crop_pkg::KEY_DOWN);
		send_key(KBD, crop_pkg::KEY_RIGHT);
		check_frame(3);
		send_key(KBD, crop_pkg::KEY_ALT_L);
		send_key(KBD, crop_pkg::KEY_UP);
		send_key(KBD, crop_pkg::KEY_UP);
		send_key(KBD, crop_pkg::KEY_LEFT);
		send_key(KBD, crop_pkg::KEY_LEFT);
		check_frame(3);
		send_key(KBD, crop_pkg::KEY_DOWN);
		send_key(KBD, crop_pkg::KEY_RIGHT);
		check_frame(3);
		send_key(KBD, crop_pkg::KEY_ALT_L_UP);
		send_key(KBD, crop_pkg::KEY_UP); // top again
		check_frame(3);
		send_key(KBD, crop_pkg::KEY_ALT_R);
		send_key(KBD, crop_pkg::KEY_LEFT);
		send_key(KBD, crop_pkg::KEY_ALT_R_UP);
		send_key(KBD, crop_pkg::KEY_LEFT);
		check_frame(3);

		// non-keyboard types and unknown codes
		send_key(2'd1, crop_pkg::KEY_UP);
		send_key(2'd0, crop_pkg::KEY_ALT_L);
		send_key(KBD, 8'h20);
		send_key(KBD, 8'hC4);
		repeat (40) @(posedge clk_sys);
		check_frame(2);
		send_key(KBD, crop_pkg::KEY_UP); // alt still released
		check_frame(3);
		send_key(KBD, crop_pkg::KEY_BACKSPACE);
		check_frame(3);

		$display("errors: %0d mismatches, %0d timeouts", mismatch_errs, timeout_errs);
		if (mismatch_errs == 0 && timeout_errs == 0)
			$display("*** PASSED ***");
		else
			$display("*** FAILED ***");
		$finish;
	end

endmodule

`default_nettype wire
